//--- memPkg.sv
`default_nettype none

package memPkg;

	//////////////////////////////
	// Major opcodes, instr[31:26]
	//////////////////////////////
	localparam logic [5:0] opLw  = 6'b100011;
	localparam logic [5:0] opLh  = 6'b100001;
	localparam logic [5:0] opLhu = 6'b100101;
	localparam logic [5:0] opLb  = 6'b100000;
	localparam logic [5:0] opLbu = 6'b100100;
	localparam logic [5:0] opSw  = 6'b101011;
	localparam logic [5:0] opSh  = 6'b101001;
	localparam logic [5:0] opSb  = 6'b101000;

	// Load kinds
	localparam logic [2:0] loadNone  = 3'd0;
	localparam logic [2:0] loadWord  = 3'd1;
	localparam logic [2:0] loadHalf  = 3'd2;
	localparam logic [2:0] loadHalfU = 3'd3;
	localparam logic [2:0] loadByte  = 3'd4;
	localparam logic [2:0] loadByteU = 3'd5;

	// Store kinds
	localparam logic [1:0] storeNone = 2'd0;
	localparam logic [1:0] storeWord = 2'd1;
	localparam logic [1:0] storeHalf = 2'd2;
	localparam logic [1:0] storeByte = 2'd3;

	//////////////////////////////
	// Timer map
	//////////////////////////////
	localparam logic [31:0] timer0Base = 32'h0000_7F00;
	localparam logic [31:0] timer1Base = 32'h0000_7F10;

	// Word index inside a timer, index 3 unmapped
	localparam logic [1:0] regCtrl   = 2'd0;
	localparam logic [1:0] regPreset = 2'd1;
	localparam logic [1:0] regCount  = 2'd2;

	// Control word bits
	localparam int ctrlEnable  = 0;
	localparam int ctrlReload  = 1;
	localparam int ctrlIrqMask = 3;

endpackage

`default_nettype wire

//--- apbIf.sv
`timescale 1ns/1ps
`default_nettype none

interface apbIf;
	logic        psel;
	logic        penable;
	logic        pwrite;
	// Register index, not a byte address
	logic [1:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;

	modport requester (
		output psel, penable, pwrite, paddr, pwdata,
		input  prdata, pready
	);

	modport completer (
		input  psel, penable, pwrite, paddr, pwdata,
		output prdata, pready
	);
endinterface

`default_nettype wire

//--- memOpDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module memOpDecoder (
	input  logic [31:0] instr,
	output logic [2:0]  loadKind,
	output logic [1:0]  storeKind,
	output logic        isLoad,
	output logic        isStore,
	output logic [1:0]  width
);
	import memPkg::*;

	logic [5:0] opcode;

	assign opcode = instr[31:26];

	// Width code: 0 byte, 1 half, 2 word
	always_comb begin
		loadKind = loadNone;
		storeKind = storeNone;
		width = 2'd0;
		case (opcode)
			opLw: begin
				loadKind = loadWord;
				width = 2'd2;
			end
			opLh: begin
				loadKind = loadHalf;
				width = 2'd1;
			end
			opLhu: begin
				loadKind = loadHalfU;
				width = 2'd1;
			end
			opLb: loadKind = loadByte;
			opLbu: loadKind = loadByteU;
			opSw: begin
				storeKind = storeWord;
				width = 2'd2;
			end
			opSh: begin
				storeKind = storeHalf;
				width = 2'd1;
			end
			opSb: storeKind = storeByte;
			default: ;
		endcase
	end

	assign isLoad = loadKind != loadNone;
	assign isStore = storeKind != storeNone;

endmodule

`default_nettype wire

//--- memAccessChecker.sv
`timescale 1ns/1ps
`default_nettype none

module memAccessChecker #(
	parameter int dataWords = 3072
) (
	input  logic [31:0] addr,
	input  logic        isLoad,
	input  logic        isStore,
	input  logic [1:0]  width,
	output logic        ramSel,
	output logic        timerSel,
	output logic        accessError
);
	import memPkg::*;

	localparam logic [31:0] ramBytes = 32'(dataWords * 4);

	logic memOp;
	logic ramHit;
	logic regMapped;
	logic timerHit;
	logic misaligned;
	logic countStore;

	assign memOp = isLoad || isStore;

	//////////////////////////////
	// Address map
	//////////////////////////////
	assign ramHit = addr < ramBytes;
	assign regMapped = addr[3:2] == regCtrl || addr[3:2] == regPreset ||
		addr[3:2] == regCount;
	assign timerHit = regMapped &&
		(addr[31:4] == timer0Base[31:4] || addr[31:4] == timer1Base[31:4]);

	//////////////////////////////
	// Exception rules
	//////////////////////////////
	assign misaligned = (width == 2'd2 && addr[1:0] != 2'b00) ||
		(width == 2'd1 && addr[0]);
	// Count register is read only
	assign countStore = isStore && timerHit && addr[3:2] == regCount;

	assign accessError = memOp && (misaligned || countStore ||
		(timerHit && width != 2'd2) || (!ramHit && !timerHit));

	always_comb begin
		ramSel = memOp && ramHit;
		timerSel = memOp && timerHit;
		// RAM depth must stay below the timer window
		assert (!(ramSel && timerSel))
			else $error("RAM and timer both selected at address %h", addr);
	end

endmodule

`default_nettype wire

//--- dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
	parameter int dataWords = 3072
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] addr,
	input  logic [2:0]  loadKind,
	input  logic [1:0]  storeKind,
	input  logic        writeEnable,
	input  logic [31:0] storeData,
	output logic [31:0] loadData
);
	import memPkg::*;

	localparam int idxBits = $clog2(dataWords);
	localparam logic [31:0] ramBytes = 32'(dataWords * 4);

	logic [31:0] mem [dataWords];
	logic [idxBits-1:0] wordIdx;
	logic [31:0] readWord;
	logic [31:0] mergedWord;
	logic [7:0] laneByte;
	logic [15:0] laneHalf;

	assign wordIdx = addr[idxBits+1:2];
	assign readWord = mem[wordIdx];

	//////////////////////////////
	// Load path
	//////////////////////////////
	assign laneByte = readWord[{addr[1:0], 3'b000} +: 8];
	assign laneHalf = readWord[{addr[1], 4'b0000} +: 16];

	always_comb begin
		case (loadKind)
			loadHalf: loadData = {{16{laneHalf[15]}}, laneHalf};
			loadHalfU: loadData = {16'd0, laneHalf};
			loadByte: loadData = {{24{laneByte[7]}}, laneByte};
			loadByteU: loadData = {24'd0, laneByte};
			default: loadData = readWord;
		endcase
	end

	//////////////////////////////
	// Store path
	//////////////////////////////
	// Unwritten lanes keep the old word
	always_comb begin
		mergedWord = readWord;
		case (storeKind)
			storeWord: mergedWord = storeData;
			storeHalf: mergedWord[{addr[1], 4'b0000} +: 16] = storeData[15:0];
			storeByte: mergedWord[{addr[1:0], 3'b000} +: 8] = storeData[7:0];
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dataWords; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEnable) begin
			mem[wordIdx] <= mergedWord;
		end
	end

	// Checker upstream must keep writes inside the array
	writeInRange: assert property (@(posedge clk) disable iff (reset)
		writeEnable |-> addr < ramBytes)
		else $error("RAM write beyond depth at address %h", addr);

endmodule

`default_nettype wire

//--- apbBridge.sv
`timescale 1ns/1ps
`default_nettype none

module apbBridge (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic [31:0] addr,
	input  logic        write,
	input  logic [31:0] storeData,
	output logic [31:0] readData,
	output logic        done,
	apbIf.requester     apb0,
	apbIf.requester     apb1
);
	import memPkg::*;

	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stSetup = 2'd1;
	localparam logic [1:0] stAccess = 2'd2;

	logic [1:0] state;
	logic [1:0] phase;
	logic [1:0] nextState;
	logic pick1;
	logic busy;
	logic ready;

	assign pick1 = addr[4] == timer1Base[4];
	// Setup phase starts in the same cycle as start
	assign phase = (state == stIdle && start) ? stSetup : state;
	assign busy = phase != stIdle;
	assign ready = pick1 ? apb1.pready : apb0.pready;

	always_comb begin
		case (phase)
			stSetup: nextState = stAccess;
			stAccess: nextState = ready ? stIdle : stAccess;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	//////////////////////////////
	// Bus drive
	//////////////////////////////
	assign apb0.psel = busy && !pick1;
	assign apb0.penable = phase == stAccess && !pick1;
	assign apb0.pwrite = write;
	assign apb0.paddr = addr[3:2];
	assign apb0.pwdata = storeData;

	assign apb1.psel = busy && pick1;
	assign apb1.penable = phase == stAccess && pick1;
	assign apb1.pwrite = write;
	assign apb1.paddr = addr[3:2];
	assign apb1.pwdata = storeData;

	assign done = phase == stAccess && ready;
	assign readData = pick1 ? apb1.prdata : apb0.prdata;

	// Access phase always follows a setup or access cycle on the same bus
	enableAfterSel0: assert property (@(posedge clk) disable iff (reset)
		apb0.penable |-> $past(apb0.psel))
		else $error("apb0 penable without prior psel");
	enableAfterSel1: assert property (@(posedge clk) disable iff (reset)
		apb1.penable |-> $past(apb1.psel))
		else $error("apb1 penable without prior psel");

endmodule

`default_nettype wire

//--- timerDevice.sv
`timescale 1ns/1ps
`default_nettype none

module timerDevice (
	input  logic     clk,
	input  logic     reset,
	apbIf.completer  apb,
	output logic     irq
);
	import memPkg::*;

	logic [3:0] ctrl;
	logic [31:0] preset;
	logic [31:0] count;
	logic writeAccess;
	logic presetWrite;

	// No wait states
	assign apb.pready = 1'b1;

	// Write lands at the end of the access phase
	assign writeAccess = apb.psel && apb.penable && apb.pwrite;
	assign presetWrite = writeAccess && apb.paddr == regPreset;

	//////////////////////////////
	// Register read
	//////////////////////////////
	always_comb begin
		case (apb.paddr)
			regCtrl: apb.prdata = {28'd0, ctrl};
			regPreset: apb.prdata = preset;
			regCount: apb.prdata = count;
			default: apb.prdata = '0;
		endcase
	end

	//////////////////////////////
	// Registers and counter
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;
			preset <= '0;
			count <= '0;
		end else begin
			if (writeAccess && apb.paddr == regCtrl) begin
				ctrl <= apb.pwdata[3:0];
			end
			if (presetWrite) begin
				preset <= apb.pwdata;
				// Preset write also restarts the count
				count <= apb.pwdata;
			end else if (ctrl[ctrlEnable]) begin
				if (count != '0) begin
					count <= count - 32'd1;
				end else if (ctrl[ctrlReload]) begin
					count <= preset;
				end
			end
		end
	end

	// Level irq while expired, enabled and unmasked
	assign irq = count == '0 && ctrl[ctrlEnable] && ctrl[ctrlIrqMask];

endmodule

`default_nettype wire

//--- memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage #(
	parameter int dataWords = 3072
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        valid,
	input  logic [31:0] instr,
	input  logic [31:0] addr,
	input  logic [31:0] storeData,
	input  logic        excInt,
	output logic [31:0] loadData,
	output logic        loadError,
	output logic        storeError,
	output logic        done,
	output logic        irq0,
	output logic        irq1
);
	logic [2:0] loadKind;
	logic [1:0] storeKind;
	logic isLoad;
	logic isStore;
	logic [1:0] width;
	logic ramSel;
	logic timerSel;
	logic accessError;
	logic ramAccess;
	logic ramWrite;
	logic timerAccess;
	logic timerStart;
	logic timerSkip;
	logic errorHit;
	logic bridgeDone;
	logic [31:0] ramLoadData;
	logic [31:0] timerReadData;

	apbIf timer0Bus ();
	apbIf timer1Bus ();

	memOpDecoder opDecoder (
		.instr(instr),
		.loadKind(loadKind),
		.storeKind(storeKind),
		.isLoad(isLoad),
		.isStore(isStore),
		.width(width)
	);

	memAccessChecker #(.dataWords(dataWords)) accessChecker (
		.addr(addr),
		.isLoad(isLoad),
		.isStore(isStore),
		.width(width),
		.ramSel(ramSel),
		.timerSel(timerSel),
		.accessError(accessError)
	);

	//////////////////////////////
	// Access gating
	//////////////////////////////
	assign errorHit = valid && accessError;
	assign ramAccess = valid && ramSel && !accessError;
	assign ramWrite = ramAccess && isStore && !excInt;
	assign timerAccess = valid && timerSel && !accessError;
	// Pending interrupt drops a timer store without a bus transfer
	assign timerSkip = timerAccess && isStore && excInt;
	assign timerStart = timerAccess && !timerSkip;

	assign loadError = errorHit && isLoad;
	assign storeError = errorHit && isStore;

	dataMemory #(.dataWords(dataWords)) ram (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.loadKind(loadKind),
		.storeKind(storeKind),
		.writeEnable(ramWrite),
		.storeData(storeData),
		.loadData(ramLoadData)
	);

	apbBridge bridge (
		.clk(clk),
		.reset(reset),
		.start(timerStart),
		.addr(addr),
		.write(isStore),
		.storeData(storeData),
		.readData(timerReadData),
		.done(bridgeDone),
		.apb0(timer0Bus.requester),
		.apb1(timer1Bus.requester)
	);

	timerDevice timer0 (
		.clk(clk),
		.reset(reset),
		.apb(timer0Bus.completer),
		.irq(irq0)
	);

	timerDevice timer1 (
		.clk(clk),
		.reset(reset),
		.apb(timer1Bus.completer),
		.irq(irq1)
	);

	assign loadData = timerSel ? timerReadData : ramLoadData;
	// RAM and error paths finish in one cycle, timers via the bridge
	assign done = ramAccess || errorHit || timerSkip || bridgeDone;

endmodule

`default_nettype wire

//--- tbMemStage.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemStage;
	import memPkg::*;

	localparam int ramWords = 3072;
	localparam logic [31:0] ramBytes = 32'(ramWords * 4);
	localparam int doneTimeout = 8;

	logic clk;
	logic reset;
	logic valid;
	logic [31:0] instr;
	logic [31:0] addr;
	logic [31:0] storeData;
	logic excInt;
	logic [31:0] loadData;
	logic loadError;
	logic storeError;
	logic done;
	logic irq0;
	logic irq1;

	// Expectations for the access in flight
	logic expTwoCycle;
	logic expCheck;
	logic [31:0] expData;
	logic expLoadErr;
	logic expStoreErr;
	logic reloadMode;

	int seed = 52612;
	logic [31:0] model [ramWords];

	memStage #(.dataWords(ramWords)) i_dut (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.instr(instr),
		.addr(addr),
		.storeData(storeData),
		.excInt(excInt),
		.loadData(loadData),
		.loadError(loadError),
		.storeError(storeError),
		.done(done),
		.irq0(irq0),
		.irq1(irq1)
	);

	always #10 clk = ~clk;

	task automatic abortRun();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		abortRun();
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////
	oneCycleDone: assert property (@(posedge clk) disable iff (reset)
		valid && !expTwoCycle |-> done)
		else reportMismatch("done", 32'd1, 32'($sampled(done)));
	setupNotDone: assert property (@(posedge clk) disable iff (reset)
		valid && expTwoCycle && !$past(valid) |-> !done)
		else reportMismatch("done", 32'd0, 32'($sampled(done)));
	accessDone: assert property (@(posedge clk) disable iff (reset)
		valid && expTwoCycle && $past(valid) |-> done)
		else reportMismatch("done", 32'd1, 32'($sampled(done)));
	loadValue: assert property (@(posedge clk) disable iff (reset)
		valid && done && expCheck |-> loadData == expData)
		else reportMismatch("loadData", $sampled(expData), $sampled(loadData));
	loadErrorFlag: assert property (@(posedge clk) disable iff (reset)
		valid && done |-> loadError == expLoadErr)
		else reportMismatch("loadError", 32'($sampled(expLoadErr)), 32'($sampled(loadError)));
	storeErrorFlag: assert property (@(posedge clk) disable iff (reset)
		valid && done |-> storeError == expStoreErr)
		else reportMismatch("storeError", 32'($sampled(expStoreErr)),
			32'($sampled(storeError)));
	idleFlagsLow: assert property (@(posedge clk) disable iff (reset)
		!valid |-> !loadError && !storeError)
		else reportMismatch("loadError/storeError", 32'd0,
			32'({$sampled(loadError), $sampled(storeError)}));
	// Reload at zero keeps irq to a single cycle
	reloadDrop: assert property (@(posedge clk) disable iff (reset)
		reloadMode && $past(irq0) |-> !irq0)
		else reportMismatch("irq0", 32'd0, 32'($sampled(irq0)));
	timer1Quiet: assert property (@(posedge clk) disable iff (reset) !irq1)
		else reportMismatch("irq1", 32'd0, 32'($sampled(irq1)));

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	function automatic logic [31:0] randAligned();
		return 32'(($unsigned($random(seed)) % ramWords) * 4);
	endfunction

	function automatic logic [31:0] timerReg(input logic [31:0] base, input logic [1:0] idx);
		return {base[31:4], idx, 2'b00};
	endfunction

	function automatic logic [31:0] mergeLanes(input logic [5:0] op, input logic [31:0] oldWord,
			input logic [31:0] a, input logic [31:0] d);
		int shift;
		logic [31:0] mask;
		if (op == opSw) begin
			shift = 0;
			mask = 32'hFFFF_FFFF;
		end else if (op == opSh) begin
			shift = a[1] ? 16 : 0;
			mask = 32'h0000_FFFF << shift;
		end else begin
			shift = 8 * int'(a[1:0]);
			mask = 32'h0000_00FF << shift;
		end
		return (oldWord & ~mask) | ((d << shift) & mask);
	endfunction

	function automatic logic [31:0] expectLoad(input logic [5:0] op, input logic [31:0] a);
		logic [31:0] word;
		logic [31:0] shifted;
		word = model[int'(a >> 2)];
		shifted = word >> (8 * int'(a[1:0]));
		case (op)
			opLh: return {{16{shifted[15]}}, shifted[15:0]};
			opLhu: return {16'd0, shifted[15:0]};
			opLb: return {{24{shifted[7]}}, shifted[7:0]};
			opLbu: return {24'd0, shifted[7:0]};
			default: return word;
		endcase
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic runAccess(input logic [5:0] op, input logic [31:0] a, input logic [31:0] d,
			input logic exc, input logic twoCycle, input logic chk, input logic [31:0] expected,
			input logic le, input logic se);
		int waited;
		logic [31:0] filler;
		filler = randWord();
		@(posedge clk);
		valid <= 1'b1;
		instr <= {op, filler[25:0]};
		addr <= a;
		storeData <= d;
		excInt <= exc;
		expTwoCycle <= twoCycle;
		expCheck <= chk;
		expData <= expected;
		expLoadErr <= le;
		expStoreErr <= se;
		waited = 0;
		@(negedge clk);
		while (!done && waited < doneTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (!done) begin
			$display("No done from the DUT within %0d cycles at address %h", doneTimeout, a);
			abortRun();
		end
		@(posedge clk);
		valid <= 1'b0;
		excInt <= 1'b0;
	endtask

	task automatic ramStore(input logic [5:0] op, input logic [31:0] a, input logic [31:0] d,
			input logic exc);
		runAccess(op, a, d, exc, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0);
		// Pending interrupt leaves the RAM alone
		if (!exc) begin
			model[int'(a >> 2)] = mergeLanes(op, model[int'(a >> 2)], a, d);
		end
	endtask

	task automatic ramLoad(input logic [5:0] op, input logic [31:0] a);
		runAccess(op, a, randWord(), 1'b0, 1'b0, 1'b1, expectLoad(op, a), 1'b0, 1'b0);
	endtask

	task automatic badAccess(input logic [5:0] op, input logic [31:0] a, input logic isSt);
		runAccess(op, a, randWord(), 1'b0, 1'b0, 1'b0, 32'd0, !isSt, isSt);
	endtask

	task automatic timerStore(input logic [31:0] a, input logic [31:0] d, input logic exc);
		runAccess(opSw, a, d, exc, !exc, 1'b0, 32'd0, 1'b0, 1'b0);
	endtask

	task automatic timerLoad(input logic [31:0] a, input logic [31:0] expected);
		runAccess(opLw, a, randWord(), 1'b0, 1'b1, 1'b1, expected, 1'b0, 1'b0);
	endtask

	task automatic checkLanes(input logic [31:0] base);
		for (int lane = 0; lane < 4; lane++) begin
			ramLoad(opLb, base + 32'(lane));
			ramLoad(opLbu, base + 32'(lane));
		end
		for (int half = 0; half < 4; half += 2) begin
			ramLoad(opLh, base + 32'(half));
			ramLoad(opLhu, base + 32'(half));
		end
		ramLoad(opLw, base);
	endtask

	task automatic waitIrq0(input logic level, input int limit, input string what);
		int waited;
		waited = 1;
		@(negedge clk);
		while (irq0 !== level && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (irq0 !== level) begin
			$display("irq0 did not %s within %0d cycles", what, limit);
			abortRun();
		end
	endtask

	initial begin
		logic [31:0] addrList [$];
		logic [31:0] target;
		logic [31:0] presetVal;
		logic [31:0] preset1Val;
		logic [31:0] ctrlRun;
		int period;
		clk = 1'b0;
		reset = 1'b1;
		valid = 1'b0;
		instr = '0;
		addr = '0;
		storeData = '0;
		excInt = 1'b0;
		expTwoCycle = 1'b0;
		expCheck = 1'b0;
		expData = '0;
		expLoadErr = 1'b0;
		expStoreErr = 1'b0;
		reloadMode = 1'b0;
		for (int i = 0; i < ramWords; i++) begin
			model[i] = '0;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// Word stores then loads
		for (int i = 0; i < 16; i++) begin
			addrList.push_back(randAligned());
			ramStore(opSw, addrList[i], randWord(), 1'b0);
		end
		foreach (addrList[i]) begin
			ramLoad(opLw, addrList[i]);
		end

		// Sub-word lanes, first with fixed signs then random
		target = randAligned();
		ramStore(opSw, target, 32'h807F_FF01, 1'b0);
		checkLanes(target);
		for (int round = 0; round < 6; round++) begin
			for (int lane = 0; lane < 4; lane++) begin
				ramStore(opSb, target + 32'(lane), randWord(), 1'b0);
			end
			ramStore(opSh, target + 32'(2 * (round % 2)), randWord(), 1'b0);
			checkLanes(target);
		end

		// Exceptions leave memory untouched
		target = randAligned();
		ramStore(opSw, target, randWord(), 1'b0);
		badAccess(opLw, target + 32'd1, 1'b0);
		badAccess(opLw, target + 32'd2, 1'b0);
		badAccess(opLh, target + 32'd1, 1'b0);
		badAccess(opSw, target + 32'd2, 1'b1);
		badAccess(opSh, target + 32'd3, 1'b1);
		badAccess(opLw, ramBytes, 1'b0);
		badAccess(opSw, ramBytes + 32'd4, 1'b1);
		badAccess(opSb, 32'h0000_5000, 1'b1);
		badAccess(opLb, timerReg(timer0Base, regPreset), 1'b0);
		badAccess(opSh, timerReg(timer1Base, regPreset), 1'b1);
		badAccess(opLw, timerReg(timer0Base, 2'd3), 1'b0);
		ramLoad(opLw, target);

		// Stores under a pending interrupt
		ramStore(opSw, target, randWord(), 1'b1);
		ramStore(opSb, target + 32'd1, randWord(), 1'b1);
		ramLoad(opLw, target);

		// Timer registers over APB
		presetVal = randWord();
		timerStore(timerReg(timer0Base, regCtrl), 32'd1 << ctrlIrqMask, 1'b0);
		timerStore(timerReg(timer0Base, regPreset), presetVal, 1'b0);
		timerLoad(timerReg(timer0Base, regPreset), presetVal);
		timerLoad(timerReg(timer0Base, regCtrl), 32'd1 << ctrlIrqMask);
		timerLoad(timerReg(timer0Base, regCount), presetVal);
		badAccess(opSw, timerReg(timer0Base, regCount), 1'b1);
		timerStore(timerReg(timer0Base, regPreset), randWord(), 1'b1);
		timerLoad(timerReg(timer0Base, regPreset), presetVal);
		preset1Val = randWord();
		timerStore(timerReg(timer1Base, regPreset), preset1Val, 1'b0);
		timerLoad(timerReg(timer1Base, regPreset), preset1Val);
		timerLoad(timerReg(timer0Base, regPreset), presetVal);

		// Timer 0 countdown, one shot then reload
		period = 4 + int'($unsigned($random(seed)) % 8);
		ctrlRun = (32'd1 << ctrlEnable) | (32'd1 << ctrlIrqMask);
		timerStore(timerReg(timer0Base, regPreset), 32'(period), 1'b0);
		timerStore(timerReg(timer0Base, regCtrl), ctrlRun, 1'b0);
		waitIrq0(1'b1, period + 3, "rise");
		timerStore(timerReg(timer0Base, regCtrl), ctrlRun | (32'd1 << ctrlReload), 1'b0);
		waitIrq0(1'b0, 4, "fall after reload was set");
		@(posedge clk);
		reloadMode <= 1'b1;
		waitIrq0(1'b1, period + 3, "rise in reload mode");
		waitIrq0(1'b0, 1, "drop on the next cycle");
		repeat (2 * period + 4) @(posedge clk);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- memStage.f
memPkg.sv
apbIf.sv
memOpDecoder.sv
memAccessChecker.sv
dataMemory.sv
apbBridge.sv
timerDevice.sv
memStage.sv
tbMemStage.sv

//--- runSim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f memStage.f \
	--top-module tbMemStage \
	-o simMemStage
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/simMemStage
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
